//--- common/alu_pkg.sv
package alu_pkg;

    // operand and result width, Q6.10
    localparam int DATA_W = 16;
    localparam int FRAC_W = 10;

    // opcode field width
    localparam int INST_W = 4;

    // step counter of the serial engine
    localparam int CNT_W = 4;

    // saturation limits of a signed Q6.10 word
    localparam logic [DATA_W-1:0] DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic [DATA_W-1:0] DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // codes 3 and 9..15 are unsupported
    typedef enum logic [INST_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_MAC  = 4'd2,
        OP_GRAY = 4'd4,
        OP_LRCW = 4'd5,
        OP_ROT  = 4'd6,
        OP_CLZ  = 4'd7,
        OP_RM4  = 4'd8
    } alu_op_e;

    // serial engine phases
    typedef enum logic [1:0] {
        SER_IDLE = 2'd0,
        SER_RUN  = 2'd1,
        SER_DONE = 2'd2
    } serial_state_e;

endpackage

//--- common/alu_opnd_if.sv
`timescale 1ns/1ps

interface alu_opnd_if;

    // captured instruction, held until the next acceptance
    alu_pkg::alu_op_e           op;
    logic [alu_pkg::DATA_W-1:0] a;
    logic [alu_pkg::DATA_W-1:0] b;

    // single-cycle op waiting for its result register
    logic                       pending;
    // kicks the serial engine
    logic                       start;

    modport ctrl (output op, a, b, pending, start);
    modport unit (input op, a, b, pending, start);

endinterface

//--- design/alu_ctrl.sv
`timescale 1ns/1ps

module alu_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_in_valid,
    input  logic [alu_pkg::INST_W-1:0] i_inst,
    input  logic [alu_pkg::DATA_W-1:0] i_data_a,
    input  logic [alu_pkg::DATA_W-1:0] i_data_b,
    output logic                       o_busy,
    output logic                       o_out_valid,
    output logic [alu_pkg::DATA_W-1:0] o_data,
    alu_opnd_if.ctrl                   opnd,
    input  logic [alu_pkg::DATA_W-1:0] i_sum,
    input  logic [alu_pkg::DATA_W-1:0] i_mac,
    input  logic [alu_pkg::DATA_W-1:0] i_gray,
    input  logic [alu_pkg::DATA_W-1:0] i_rm4,
    input  logic [alu_pkg::DATA_W-1:0] i_ser_result,
    input  logic                       i_ser_done
);

    logic                       accept;
    logic                       is_single;
    logic                       is_serial;
    logic [alu_pkg::DATA_W-1:0] result_sel;

    // serial ops hold off new instructions
    assign accept = i_in_valid && !o_busy;

    // opcode class, unsupported codes fall in neither
    always_comb begin
        is_single = 1'b0;
        is_serial = 1'b0;
        case (i_inst)
            alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_MAC,
            alu_pkg::OP_GRAY, alu_pkg::OP_RM4: is_single = 1'b1;
            alu_pkg::OP_ROT, alu_pkg::OP_CLZ, alu_pkg::OP_LRCW: is_serial = 1'b1;
            default: ;
        endcase
    end

    // operand capture
    always_ff @(posedge i_clk) begin
        if (accept) begin
            opnd.op <= alu_pkg::alu_op_e'(i_inst);
            opnd.a  <= i_data_a;
            opnd.b  <= i_data_b;
        end
    end

    // strobes and busy flag
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            opnd.pending <= 1'b0;
            opnd.start   <= 1'b0;
            o_busy       <= 1'b0;
        end else begin
            opnd.pending <= accept && is_single;
            opnd.start   <= accept && is_serial;
            if (accept && is_serial) begin
                o_busy <= 1'b1;
            end else if (i_ser_done) begin
                // drops on the same edge the result is registered
                o_busy <= 1'b0;
            end
        end
    end

    // pick the unit that owns the captured op
    always_comb begin
        case (opnd.op)
            alu_pkg::OP_ADD,
            alu_pkg::OP_SUB:  result_sel = i_sum;
            alu_pkg::OP_MAC:  result_sel = i_mac;
            alu_pkg::OP_GRAY: result_sel = i_gray;
            alu_pkg::OP_RM4:  result_sel = i_rm4;
            // serial ops, op stays put while busy
            default:          result_sel = i_ser_result;
        endcase
    end

    // output register and valid pulse
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_valid <= 1'b0;
            o_data      <= '0;
        end else begin
            o_out_valid <= opnd.pending || i_ser_done;
            if (opnd.pending || i_ser_done) begin
                o_data <= result_sel;
            end
        end
    end

    // captured operands never move during a serial op
    a_no_accept_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_busy |=> $stable(opnd.op) && $stable(opnd.a) && $stable(opnd.b));

    // only one result per serial op
    a_single_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_out_valid && o_busy |=> !o_out_valid);

    // serial engine finishes only what was started
    a_done_in_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ser_done |-> o_busy);

endmodule

//--- design/alu_bitops.sv
`timescale 1ns/1ps

module alu_bitops (
    alu_opnd_if.unit                   opnd,
    output logic [alu_pkg::DATA_W-1:0] o_gray,
    output logic [alu_pkg::DATA_W-1:0] o_rm4
);

    // binary to gray, msb passes through
    always_comb begin
        for (int i = 0; i < alu_pkg::DATA_W - 1; i++) begin
            o_gray[i] = opnd.a[i+1] ^ opnd.a[i];
        end
        o_gray[alu_pkg::DATA_W-1] = opnd.a[alu_pkg::DATA_W-1];
    end

    // nibble of a against the mirrored nibble of b
    always_comb begin
        o_rm4 = '0;
        for (int i = 0; i < alu_pkg::DATA_W - 3; i++) begin
            o_rm4[i] = (opnd.a[i+:4] == opnd.b[alu_pkg::DATA_W-1-i-:4]);
        end
        // top three bits have no full window
    end

endmodule

//--- arith/alu_addsub.sv
`timescale 1ns/1ps

module alu_addsub (
    alu_opnd_if.unit                   opnd,
    output logic [alu_pkg::DATA_W-1:0] o_sum
);

    logic [alu_pkg::DATA_W:0] a_ext;
    logic [alu_pkg::DATA_W:0] b_ext;
    logic [alu_pkg::DATA_W:0] sum;
    logic                     ovf;

    // one extra sign bit so -DATA_MIN still fits
    assign a_ext = {opnd.a[alu_pkg::DATA_W-1], opnd.a};
    assign b_ext = (opnd.op == alu_pkg::OP_SUB) ?
                   (~{opnd.b[alu_pkg::DATA_W-1], opnd.b} + 1'b1) :
                   {opnd.b[alu_pkg::DATA_W-1], opnd.b};

    assign sum = a_ext + b_ext;

    // top two bits disagree on signed overflow
    assign ovf = sum[alu_pkg::DATA_W] ^ sum[alu_pkg::DATA_W-1];

    // clamp toward the sign of the true result
    assign o_sum = !ovf ? sum[alu_pkg::DATA_W-1:0] :
                   sum[alu_pkg::DATA_W] ? alu_pkg::DATA_MIN : alu_pkg::DATA_MAX;

endmodule

//--- arith/alu_mac.sv
`timescale 1ns/1ps

module alu_mac #(
    parameter int MAC_GUARD_W = 4
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    alu_opnd_if.unit                   opnd,
    output logic [alu_pkg::DATA_W-1:0] o_mac
);

    localparam int PROD_W = 2 * alu_pkg::DATA_W;
    localparam int ACC_W  = PROD_W + MAC_GUARD_W;
    // magnitude after dropping the fraction, plus a carry bit
    localparam int RND_W  = ACC_W - alu_pkg::FRAC_W + 1;

    localparam logic [ACC_W-1:0] ACC_MAX = {1'b0, {(ACC_W-1){1'b1}}};
    localparam logic [ACC_W-1:0] ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};
    localparam logic [RND_W-1:0] LIM_POS = {{(RND_W-alu_pkg::DATA_W){1'b0}}, alu_pkg::DATA_MAX};
    localparam logic [RND_W-1:0] LIM_NEG = LIM_POS + 1'b1;

    logic signed [PROD_W-1:0] prod;
    logic [ACC_W-1:0]         prod_ext;
    logic [ACC_W-1:0]         acc;
    logic [ACC_W:0]           sum;
    logic                     ovf;
    logic [ACC_W-1:0]         acc_nx;
    logic                     neg;
    logic [ACC_W-1:0]         mag;
    logic [RND_W-1:0]         rnd;
    logic                     mac_en;

    // full Q12.20 product
    assign prod     = $signed(opnd.a) * $signed(opnd.b);
    assign prod_ext = {{MAC_GUARD_W{prod[PROD_W-1]}}, prod};

    // guarded add, saturates at the accumulator width
    assign sum    = {acc[ACC_W-1], acc} + {prod_ext[ACC_W-1], prod_ext};
    assign ovf    = sum[ACC_W] ^ sum[ACC_W-1];
    assign acc_nx = !ovf ? sum[ACC_W-1:0] : (sum[ACC_W] ? ACC_MIN : ACC_MAX);

    assign mac_en = opnd.pending && (opnd.op == alu_pkg::OP_MAC);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc <= '0;
        end else if (mac_en) begin
            acc <= acc_nx;
        end
    end

    // sign-magnitude rounding, half up on the magnitude
    assign neg = acc_nx[ACC_W-1];
    assign mag = neg ? (~acc_nx + 1'b1) : acc_nx;
    assign rnd = {1'b0, mag[ACC_W-1:alu_pkg::FRAC_W]} + mag[alu_pkg::FRAC_W-1];

    // back to Q6.10, negative side reaches one step further
    always_comb begin
        if (neg) begin
            o_mac = (rnd > LIM_NEG) ? alu_pkg::DATA_MIN :
                    (~rnd[alu_pkg::DATA_W-1:0] + 1'b1);
        end else begin
            o_mac = (rnd > LIM_POS) ? alu_pkg::DATA_MAX : rnd[alu_pkg::DATA_W-1:0];
        end
    end

    // accumulator only moves on a pending MAC
    a_acc_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !mac_en |=> $stable(acc));

endmodule

//--- serial/alu_serial.sv
`timescale 1ns/1ps

module alu_serial (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    alu_opnd_if.unit                   opnd,
    output logic                       o_done,
    output logic [alu_pkg::DATA_W-1:0] o_result
);

    localparam int DW = alu_pkg::DATA_W;
    localparam int CW = alu_pkg::CNT_W;

    alu_pkg::serial_state_e state;
    alu_pkg::serial_state_e state_nx;
    logic [CW-1:0]          cnt;
    logic [CW-1:0]          cnt_nx;
    logic [DW-1:0]          work;
    logic [DW-1:0]          work_nx;

    // shift left, complement of old msb into bit 0
    function automatic logic [DW-1:0] lrcw_step(input logic [DW-1:0] w);
        lrcw_step = {w[DW-2:0], ~w[DW-1]};
    endfunction

    always_comb begin
        state_nx = state;
        cnt_nx   = cnt;
        work_nx  = work;
        case (state)
            alu_pkg::SER_IDLE: begin
                if (opnd.start) begin
                    state_nx = alu_pkg::SER_RUN;
                    cnt_nx   = '0;
                    case (opnd.op)
                        alu_pkg::OP_ROT: begin
                            work_nx = opnd.a;
                            // zero rotate finishes on load
                            if (opnd.b[CW-1:0] == '0) begin
                                state_nx = alu_pkg::SER_DONE;
                            end
                        end
                        alu_pkg::OP_LRCW: begin
                            // bit 0 of a handled while loading
                            work_nx = opnd.a[0] ? lrcw_step(opnd.b) : opnd.b;
                            cnt_nx  = CW'(1);
                        end
                        default: begin
                            // clz, msb checked on load
                            cnt_nx = CW'(1);
                            if (opnd.a == '0) begin
                                work_nx  = DW'(DW);
                                state_nx = alu_pkg::SER_DONE;
                            end else if (opnd.a[DW-1]) begin
                                work_nx  = '0;
                                state_nx = alu_pkg::SER_DONE;
                            end
                        end
                    endcase
                end
            end
            alu_pkg::SER_RUN: begin
                cnt_nx = cnt + 1'b1;
                case (opnd.op)
                    alu_pkg::OP_ROT: begin
                        work_nx = {work[0], work[DW-1:1]};
                        if (cnt_nx == opnd.b[CW-1:0]) begin
                            state_nx = alu_pkg::SER_DONE;
                        end
                    end
                    alu_pkg::OP_LRCW: begin
                        if (opnd.a[cnt]) begin
                            work_nx = lrcw_step(work);
                        end
                        // last bit of a
                        if (cnt == CW'(DW - 1)) begin
                            state_nx = alu_pkg::SER_DONE;
                        end
                    end
                    default: begin
                        if (opnd.a[DW-1-cnt]) begin
                            work_nx  = DW'(cnt);
                            state_nx = alu_pkg::SER_DONE;
                        end else if (cnt == CW'(DW - 2)) begin
                            // a is nonzero, so the one sits in bit 0
                            work_nx  = DW'(DW - 1);
                            state_nx = alu_pkg::SER_DONE;
                        end
                    end
                endcase
            end
            alu_pkg::SER_DONE: state_nx = alu_pkg::SER_IDLE;
            default:           state_nx = alu_pkg::SER_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= alu_pkg::SER_IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nx;
            cnt   <= cnt_nx;
        end
    end

    // working copy, also holds the final result
    always_ff @(posedge i_clk) begin
        work <= work_nx;
    end

    // one cycle in SER_DONE gives the pulse
    assign o_done   = (state == alu_pkg::SER_DONE);
    assign o_result = work;

    // control never restarts a running engine
    a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        opnd.start |-> state == alu_pkg::SER_IDLE);

endmodule

//--- design/alu_top.sv
`timescale 1ns/1ps

module alu_top #(
    parameter int MAC_GUARD_W = 4
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_in_valid,
    input  logic [alu_pkg::INST_W-1:0] i_inst,
    input  logic [alu_pkg::DATA_W-1:0] i_data_a,
    input  logic [alu_pkg::DATA_W-1:0] i_data_b,
    output logic                       o_busy,
    output logic                       o_out_valid,
    output logic [alu_pkg::DATA_W-1:0] o_data
);

    // per-unit results back to the output mux
    logic [alu_pkg::DATA_W-1:0] sum;
    logic [alu_pkg::DATA_W-1:0] mac;
    logic [alu_pkg::DATA_W-1:0] gray;
    logic [alu_pkg::DATA_W-1:0] rm4;
    logic [alu_pkg::DATA_W-1:0] ser_result;
    logic                       ser_done;

    // captured operands, shared by all units
    alu_opnd_if opnd ();

    alu_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_in_valid   (i_in_valid),
        .i_inst       (i_inst),
        .i_data_a     (i_data_a),
        .i_data_b     (i_data_b),
        .o_busy       (o_busy),
        .o_out_valid  (o_out_valid),
        .o_data       (o_data),
        .opnd         (opnd.ctrl),
        .i_sum        (sum),
        .i_mac        (mac),
        .i_gray       (gray),
        .i_rm4        (rm4),
        .i_ser_result (ser_result),
        .i_ser_done   (ser_done)
    );

    alu_addsub u_addsub (
        .opnd  (opnd.unit),
        .o_sum (sum)
    );

    alu_mac #(
        .MAC_GUARD_W (MAC_GUARD_W)
    ) u_mac (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .opnd    (opnd.unit),
        .o_mac   (mac)
    );

    alu_bitops u_bitops (
        .opnd   (opnd.unit),
        .o_gray (gray),
        .o_rm4  (rm4)
    );

    alu_serial u_serial (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .opnd     (opnd.unit),
        .o_done   (ser_done),
        .o_result (ser_result)
    );

endmodule

//--- tests/alu_checker.sv
`timescale 1ns/1ps

module alu_checker #(
    parameter int MAC_GUARD_W = 4
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_in_valid,
    input  logic [alu_pkg::INST_W-1:0] i_inst,
    input  logic [alu_pkg::DATA_W-1:0] i_data_a,
    input  logic [alu_pkg::DATA_W-1:0] i_data_b,
    input  logic                       i_busy,
    input  logic                       i_out_valid,
    input  logic [alu_pkg::DATA_W-1:0] i_data,
    input  logic [2:0]                 i_test_id,
    input  logic                       i_test_end,
    input  logic                       i_last,
    output int                         o_errors,
    output int                         o_outstanding
);

    localparam int ACC_W = 32 + MAC_GUARD_W;

    // model accumulator, wide enough for any guard width used here
    longint      acc_model;
    // expected result with the serial flag on top, and the accept cycle
    logic [16:0] want_q[$];
    int          cyc_q[$];
    int          cyc;
    int          test_acc;
    int          test_res;
    int          test_err;
    int          total_res;
    // serial op in flight, expected level of o_busy
    bit          busy_model;
    // o_busy has no defined level before the first reset
    bit          rst_seen;

    function automatic logic [15:0] sat16(input longint v);
        if (v > 32767) return 16'h7fff;
        if (v < -32768) return 16'h8000;
        return 16'(v);
    endfunction

    // accumulate, clamp to ACC_W signed, then round the magnitude half up
    function automatic logic [15:0] mac_step(input logic [15:0] a, input logic [15:0] b);
        longint lim;
        longint mag;
        longint rnd;
        lim = longint'(1) << (ACC_W - 1);
        acc_model += longint'($signed(a)) * longint'($signed(b));
        if (acc_model >= lim) acc_model = lim - 1;
        else if (acc_model < -lim) acc_model = -lim;
        mag = (acc_model < 0) ? -acc_model : acc_model;
        rnd = (mag >> alu_pkg::FRAC_W) + ((mag >> (alu_pkg::FRAC_W - 1)) & 1);
        if (acc_model < 0) return (rnd > 32768) ? 16'h8000 : 16'(-rnd);
        return (rnd > 32767) ? 16'h7fff : 16'(rnd);
    endfunction

    function automatic logic [15:0] predict(input logic [3:0] op, input logic [15:0] a,
                                            input logic [15:0] b);
        logic [15:0] w;
        int          n;
        w = '0;
        n = 0;
        case (op)
            alu_pkg::OP_ADD:  return sat16(longint'($signed(a)) + longint'($signed(b)));
            alu_pkg::OP_SUB:  return sat16(longint'($signed(a)) - longint'($signed(b)));
            alu_pkg::OP_MAC:  return mac_step(a, b);
            alu_pkg::OP_GRAY: return a ^ (a >> 1);
            alu_pkg::OP_RM4: begin
                // window i of a against b taken from the other end
                for (int i = 0; i <= 12; i++) begin
                    w[i] = ((a >> i) & 16'hf) == ((b >> (12 - i)) & 16'hf);
                end
                return w;
            end
            alu_pkg::OP_ROT: begin
                n = int'(b[3:0]);
                return (a >> n) | (a << (16 - n));
            end
            alu_pkg::OP_CLZ: begin
                while (n < 16 && a[15-n] == 1'b0) n++;
                return 16'(n);
            end
            alu_pkg::OP_LRCW: begin
                w = b;
                for (int i = 0; i < 16; i++) if (a[i]) w = {w[14:0], ~w[15]};
                return w;
            end
            default: return '0;
        endcase
    endfunction

    function automatic logic is_serial(input logic [3:0] op);
        return op == alu_pkg::OP_ROT || op == alu_pkg::OP_CLZ || op == alu_pkg::OP_LRCW;
    endfunction

    function automatic logic is_supported(input logic [3:0] op);
        return is_serial(op) || op == alu_pkg::OP_ADD || op == alu_pkg::OP_SUB ||
               op == alu_pkg::OP_MAC || op == alu_pkg::OP_GRAY || op == alu_pkg::OP_RM4;
    endfunction

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "reset, add and sub";
            3'd2:    return "mac";
            3'd3:    return "gray and rm4";
            3'd4:    return "serial ops";
            default: return "busy and unsupported";
        endcase
    endfunction

    task automatic fail_value(input string name, input logic [15:0] want, input logic [15:0] got);
        $display("FAIL %s expected 0x%h actual 0x%h", name, want, got);
        o_errors++;
        test_err++;
    endtask

    task automatic fail_text(input string msg);
        $display("error: %s", msg);
        o_errors++;
        test_err++;
    endtask

    task automatic report_test();
        if (want_q.size() != 0) fail_text($sformatf("%0d results never arrived", want_q.size()));
        want_q.delete();
        cyc_q.delete();
        $display("test %0d %s: %0d accepted, %0d results, %0d errors",
                 i_test_id, test_name(i_test_id), test_acc, test_res, test_err);
        if (i_last) $display("summary: %0d tests, %0d results checked, %0d errors",
                             i_test_id, total_res, o_errors);
        test_acc = 0;
        test_res = 0;
        test_err = 0;
    endtask

    // sample mid-cycle, well away from the edges the tb drives on
    always @(negedge i_clk) begin
        logic [16:0] want;
        int          lat;
        cyc++;
        if (!i_rst_n) begin
            if (i_busy !== 1'b0) fail_value("o_busy", 16'h0, {15'h0, i_busy});
            if (i_out_valid !== 1'b0) fail_value("o_out_valid", 16'h0, {15'h0, i_out_valid});
            if (i_data !== 16'h0) fail_value("o_data", 16'h0, i_data);
            want_q.delete();
            cyc_q.delete();
            acc_model  = 0;
            busy_model = 1'b0;
            rst_seen   = 1'b1;
        end else begin
            if (i_out_valid && want_q.size() == 0) begin
                fail_text("result pulse with no instruction outstanding");
            end else if (i_out_valid) begin
                want = want_q.pop_front();
                // accept seen one negedge before its edge
                lat  = cyc - cyc_q.pop_front() - 1;
                test_res++;
                total_res++;
                if (i_data !== want[15:0]) fail_value("o_data", want[15:0], i_data);
                if (!want[16] && lat != 1)
                    fail_text($sformatf("single-cycle result came %0d cycles late", lat));
                if (want[16] && (lat < 2 || lat > 17))
                    fail_text($sformatf("serial result took %0d cycles", lat));
                // busy ends on the serial result edge
                if (want[16]) busy_model = 1'b0;
            end
            // high from a serial accept up to its result edge
            if (rst_seen && i_busy !== busy_model)
                fail_value("o_busy", {15'h0, busy_model}, {15'h0, i_busy});
            // unsupported codes are taken but leave no trace
            if (i_in_valid && !busy_model && is_supported(i_inst)) begin
                want_q.push_back({is_serial(i_inst), predict(i_inst, i_data_a, i_data_b)});
                cyc_q.push_back(cyc);
                test_acc++;
                if (is_serial(i_inst)) busy_model = 1'b1;
            end
        end
        if (i_test_end) report_test();
        o_outstanding = want_q.size();
    end

endmodule

//--- tests/tb_alu.sv
`timescale 1ns/1ps

module tb_alu;

    localparam int MAC_GUARD_W = 4;
    localparam int N_ARITH     = 40;
    localparam int N_MAC       = 48;
    localparam int N_BITOPS    = 30;
    localparam int N_SERIAL    = 30;
    localparam int N_MISC      = 30;
    // 20 cycles per instruction covers the slowest serial op, margin for resets and drains
    localparam int CYCLE_LIMIT = 20 * (N_ARITH + N_MAC + N_BITOPS + N_SERIAL + N_MISC) + 300;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [3:0]  inst;
    logic [15:0] data_a;
    logic [15:0] data_b;
    logic        busy;
    logic        out_valid;
    logic [15:0] data_out;
    logic [2:0]  test_id;
    logic        test_end;
    logic        last;
    int          errors;
    int          outstanding;
    int          cycles;
    integer      seed;

    always #4 clk = ~clk;

    alu_top #(.MAC_GUARD_W(MAC_GUARD_W)) i_dut (
        .i_clk (clk), .i_rst_n (rst_n), .i_in_valid (in_valid), .i_inst (inst),
        .i_data_a (data_a), .i_data_b (data_b),
        .o_busy (busy), .o_out_valid (out_valid), .o_data (data_out)
    );

    alu_checker #(.MAC_GUARD_W(MAC_GUARD_W)) u_checker (
        .i_clk (clk), .i_rst_n (rst_n), .i_in_valid (in_valid), .i_inst (inst),
        .i_data_a (data_a), .i_data_b (data_b), .i_busy (busy),
        .i_out_valid (out_valid), .i_data (data_out), .i_test_id (test_id),
        .i_test_end (test_end), .i_last (last),
        .o_errors (errors), .o_outstanding (outstanding)
    );

    // mostly random, often right at the saturation limits
    function automatic logic [15:0] pick_operand();
        logic [15:0] r;
        r = 16'($random(seed));
        case ($random(seed) & 7)
            0:       return 16'h7fff;
            1:       return 16'h8000;
            2:       return 16'h7fff - {8'h00, r[7:0]};
            3:       return 16'h8000 + {8'h00, r[7:0]};
            default: return r;
        endcase
    endfunction

    task automatic issue(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b);
        @(posedge clk);
        #1;
        // stray requests while busy, the DUT has to drop them
        while (busy) begin
            in_valid = 1'($random(seed));
            inst     = 4'($random(seed));
            data_a   = 16'($random(seed));
            data_b   = 16'($random(seed));
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        inst     = op;
        data_a   = a;
        data_b   = b;
    endtask

    // wait for all results, bounded in case one never comes
    task automatic wait_idle();
        int n;
        n = 0;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (outstanding != 0 && n < 40) begin
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic end_test(input logic [2:0] id, input logic is_last);
        wait_idle();
        test_id  = id;
        last     = is_last;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    initial begin
        int          op_sel;
        logic [15:0] a;
        clk      = 1'b0;
        rst_n    = 1'b1;
        in_valid = 1'b0;
        inst     = '0;
        data_a   = '0;
        data_b   = '0;
        test_id  = '0;
        test_end = 1'b0;
        last     = 1'b0;
        seed     = 85892;
        apply_reset();

        // back to back add and sub
        for (int i = 0; i < N_ARITH; i++)
            issue(($random(seed) & 1) ? alu_pkg::OP_SUB : alu_pkg::OP_ADD,
                  pick_operand(), pick_operand());
        end_test(3'd1, 1'b0);

        // 34 products of 2^30 overrun the 36-bit accumulator, then reset mid-run
        for (int i = 0; i < 40; i++) begin
            if (i < 34) issue(alu_pkg::OP_MAC, 16'h8000, 16'h8000);
            else issue(alu_pkg::OP_MAC, pick_operand(), pick_operand());
        end
        wait_idle();
        apply_reset();
        for (int i = 40; i < N_MAC; i++) issue(alu_pkg::OP_MAC, pick_operand(), pick_operand());
        end_test(3'd2, 1'b0);

        for (int i = 0; i < N_BITOPS; i++)
            issue(($random(seed) & 1) ? alu_pkg::OP_RM4 : alu_pkg::OP_GRAY,
                  16'($random(seed)), 16'($random(seed)));
        end_test(3'd3, 1'b0);

        // corner operands first
        issue(alu_pkg::OP_CLZ, 16'h0000, 16'h0000);
        issue(alu_pkg::OP_CLZ, 16'h0001, 16'h0000);
        issue(alu_pkg::OP_CLZ, 16'h8000, 16'h0000);
        issue(alu_pkg::OP_LRCW, 16'h0000, 16'($random(seed)));
        issue(alu_pkg::OP_LRCW, 16'hffff, 16'($random(seed)));
        issue(alu_pkg::OP_ROT, 16'($random(seed)), 16'h0010);
        for (int i = 6; i < N_SERIAL; i++) begin
            op_sel = $unsigned($random(seed)) % 3;
            a      = 16'($random(seed));
            if (op_sel == 0) issue(alu_pkg::OP_ROT, a, 16'($random(seed)));
            // spread the leading zero count
            else if (op_sel == 1) issue(alu_pkg::OP_CLZ, a >> ($random(seed) & 15), 16'h0000);
            else issue(alu_pkg::OP_LRCW, a, 16'($random(seed)));
        end
        end_test(3'd4, 1'b0);

        // any code, then an unsupported one right before a MAC
        for (int i = 2; i < N_MISC; i++) issue(4'($random(seed)), pick_operand(), pick_operand());
        issue(4'd3, pick_operand(), pick_operand());
        issue(alu_pkg::OP_MAC, 16'h0400, 16'h0400);
        end_test(3'd5, 1'b1);

        @(posedge clk);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: no verdict after %0d cycles, the DUT stopped responding", CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- tb.f
common/alu_pkg.sv
common/alu_opnd_if.sv
design/alu_ctrl.sv
design/alu_bitops.sv
arith/alu_addsub.sv
arith/alu_mac.sv
serial/alu_serial.sv
design/alu_top.sv
tests/alu_checker.sv
tests/tb_alu.sv

//--- run.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_alu -o tb_alu

# a crash or assertion stop simply leaves no pass line behind
out=$(./obj_dir/tb_alu || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
